//--- filelist.f
hw/cpu_pkg.sv
hw/cpu_alu.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/word_mem.sv
hw/pipe_core.sv
hw/boot_ctrl.sv
hw/cpu_top.sv
tb/cpu_properties.sv
tb/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, fail status when the log reports failure
set -euo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f filelist.f --top-module cpu_tb -Mdir obj_dir -o cpu_sim

./obj_dir/cpu_sim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run.sh: testbench reported failure"
    exit 1
fi
echo "run.sh: testbench finished without failure"

//--- tb/cpu_tb.sv
// directed boot and run tests; every program image ends in halt and host latencies stay within 0..3
`timescale 1ns/10ps
module cpu_tb import cpu_pkg::*; ();

    localparam int PRE_READY      = 6;    // idle cycles checked before ready
    localparam int QUIET_CYCLES   = 16;   // window after the last expected write
    localparam int N_TESTS        = 4;
    localparam int BLOCK_CYCLES   = 3 + BLOCK_WORDS + 3;   // worst latency, words, handshake
    localparam int LOAD_CYCLES    = (DM_BLOCKS + IM_BLOCKS) * BLOCK_CYCLES;
    localparam int RUN_CYCLES     = 8 + PRE_READY + 3 * MEM_WORDS + 6 * MEM_WORDS + QUIET_CYCLES;
    localparam int TIMEOUT_CYCLES = N_TESTS * (LOAD_CYCLES + RUN_CYCLES);

    logic                   clk, rst_n, ready, rd_valid, tx_done;
    word_t                  load_data, store_data;
    host_op_t               host_op;
    logic [HOST_ADDR_W-1:0] host_addr;

    integer      seed;
    int          checks, mismatches, faults, cycle_count, prog_len;
    instr_t      im_img [MEM_WORDS];
    word_t       dm_img [MEM_WORDS];
    logic [15:0] exp_addr_q [$];   // expected host writes, program order
    word_t       exp_data_q [$];

    cpu_top cpu_top_inst (
        .clk(clk), .rst_n(rst_n), .ready(ready), .rd_valid(rd_valid), .tx_done(tx_done),
        .load_data(load_data), .host_op(host_op), .host_addr(host_addr),
        .store_data(store_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the DUT made no progress within %0d cycles", cycle_count);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////
    task automatic op_check(input host_op_t got, input host_op_t want, input string what);
        checks++;
        if (got !== want) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", what, got, want);
        end
    endtask

    task automatic addr_check(input logic [HOST_ADDR_W-1:0] got,
                              input logic [HOST_ADDR_W-1:0] want, input string what);
        checks++;
        if (got !== want) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", what, got, want);
        end
    endtask

    task automatic word_check(input word_t got, input word_t want, input string what);
        checks++;
        if (got !== want) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", what, got, want);
        end
    endtask

    ////////////////////////////////////////
    // program images
    ////////////////////////////////////////
    function automatic instr_t encode(input logic [7:0] op, input reg_idx_t dst,
                                      input reg_idx_t src, input logic [15:0] imm);
        instr_t ins;
        ins.opcode = op;
        ins.rd     = dst;
        ins.rs     = src;
        ins.imm    = imm;
        return ins;
    endfunction

    // rt sits in the top nibble of imm
    function automatic instr_t rr_form(input alu_op_t op, input reg_idx_t dst,
                                       input reg_idx_t a, input reg_idx_t b);
        return encode(op, dst, a, {b, 12'h000});
    endfunction

    task automatic emit(input instr_t ins);
        im_img[prog_len] = ins;
        prog_len++;
    endtask

    task automatic reset_image();
        prog_len = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            im_img[i] = encode(HALT, 4'd0, 4'd0, 16'h0000);   // stray fetches stop
            dm_img[i] = $random(seed);
        end
    endtask

    // ISA level model, one instruction per step
    task automatic model_program();
        word_t       regs [16];
        word_t       dmem [MEM_WORDS];
        word_t       a, b, sum;
        instr_t      ins;
        logic [15:0] addr;
        int          pc, steps;
        bit          halted;
        exp_addr_q.delete();
        exp_data_q.delete();
        for (int i = 0; i < 16; i++)
            regs[i] = '0;
        dmem   = dm_img;
        pc     = 0;
        steps  = 0;
        halted = 1'b0;
        while (!halted && steps < 4 * MEM_WORDS) begin
            ins  = im_img[pc];
            a    = regs[ins.rs];
            b    = regs[ins.imm[15:12]];
            sum  = a + {{16{ins.imm[15]}}, ins.imm};
            addr = sum[15:0];
            case (alu_op_t'(ins.opcode))
                ADD:  regs[ins.rd] = a + b;
                SUB:  regs[ins.rd] = a - b;
                AND:  regs[ins.rd] = a & b;
                OR:   regs[ins.rd] = a | b;
                XOR:  regs[ins.rd] = a ^ b;
                ADDI: regs[ins.rd] = sum;
                LDW:  regs[ins.rd] = dmem[addr[6:2]];
                STW: begin
                    if (addr >= HOST_BASE) begin
                        exp_addr_q.push_back(addr);
                        exp_data_q.push_back(regs[ins.rd]);
                    end else begin
                        dmem[addr[6:2]] = regs[ins.rd];
                    end
                end
                HALT:    halted = 1'b1;
                default: ;
            endcase
            pc = (pc + 1) % MEM_WORDS;
            steps++;
        end
    endtask

    ////////////////////////////////////////
    // host model
    ////////////////////////////////////////
    task automatic apply_reset();
        @(posedge clk);
        rst_n     <= 1'b0;
        ready     <= 1'b0;
        rd_valid  <= 1'b0;
        tx_done   <= 1'b0;
        load_data <= '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic boot_host();
        logic [15:0]            base;
        logic [HOST_ADDR_W-1:0] want;
        int                     lat, idx;
        for (int blk = 0; blk < DM_BLOCKS + IM_BLOCKS; blk++) begin
            if (blk < DM_BLOCKS)
                base = DM_BLOCK_BASE[blk];
            else
                base = IM_BLOCK_BASE[blk - DM_BLOCKS];
            want                = '0;
            want[15:0]          = base;
            want[IM_SPACE_BIT]  = (blk >= DM_BLOCKS);
            do @(negedge clk); while (host_op == IDLE);
            op_check(host_op, READ, "host_op");
            addr_check(host_addr, want, "host_addr");
            lat = $random(seed) & 3;
            repeat (lat) @(posedge clk);
            for (int w = 0; w < BLOCK_WORDS; w++) begin
                idx = int'(base[6:2]) + w;
                @(posedge clk);
                rd_valid <= (w == 0);
                tx_done  <= (w == BLOCK_WORDS - 1);   // ends with word 15
                if (blk < DM_BLOCKS)
                    load_data <= dm_img[idx];
                else
                    load_data <= word_t'(im_img[idx]);
            end
            @(posedge clk);
            rd_valid <= 1'b0;
            tx_done  <= 1'b0;
        end
    endtask

    task automatic serve_writes(input bit random_delay);
        int got, lat;
        bit extra;
        got   = 0;
        extra = 1'b0;
        while (got < exp_addr_q.size()) begin
            @(negedge clk);
            if (host_op != IDLE) begin
                op_check(host_op, WRITE, "host_op");
                addr_check(host_addr, HOST_ADDR_W'(exp_addr_q[got]), "host_addr");
                word_check(store_data, exp_data_q[got], "store_data");
                got++;
                lat = random_delay ? ($random(seed) & 3) : 0;
                repeat (lat) @(posedge clk);
                @(posedge clk);
                tx_done <= 1'b1;
                @(posedge clk);
                tx_done <= 1'b0;
            end
        end
        repeat (QUIET_CYCLES) begin   // nothing may follow halt
            @(negedge clk);
            if (host_op != IDLE && !extra) begin
                extra = 1'b1;
                faults++;
                $display("Error: host transfer seen after the last expected write");
            end
        end
    endtask

    task automatic run_program(input bit random_delay);
        model_program();
        apply_reset();
        repeat (PRE_READY) begin
            @(negedge clk);
            op_check(host_op, IDLE, "host_op");
        end
        @(posedge clk);
        ready <= 1'b1;
        boot_host();
        serve_writes(random_delay);
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic alu_chain_test();
        reset_image();
        emit(encode(ADDI, 4'd1, 4'd0, 16'h7A5C));
        emit(encode(ADDI, 4'd2, 4'd1, 16'h1234));   // back to back on r1
        emit(rr_form(ADD, 4'd3, 4'd1, 4'd2));
        emit(rr_form(SUB, 4'd4, 4'd3, 4'd1));
        emit(rr_form(AND, 4'd5, 4'd4, 4'd3));
        emit(rr_form(OR, 4'd6, 4'd5, 4'd2));
        emit(rr_form(XOR, 4'd7, 4'd6, 4'd4));
        emit(encode(ADDI, 4'd8, 4'd7, 16'hFFF9));   // negative imm
        for (int r = 3; r <= 8; r++)
            emit(encode(STW, reg_idx_t'(r), 4'd0, 16'h9000 + 16'(4 * (r - 3))));
        emit(encode(HALT, 4'd0, 4'd0, 16'h0000));
        run_program(1'b0);
    endtask

    task automatic load_return_test();
        reset_image();
        emit(encode(LDW, 4'd1, 4'd0, 16'h0004));
        emit(encode(STW, 4'd1, 4'd0, 16'h9100));
        emit(encode(LDW, 4'd2, 4'd0, 16'h0044));    // second data block
        emit(encode(STW, 4'd2, 4'd0, 16'h9104));
        emit(encode(ADDI, 4'd3, 4'd0, 16'h0020));
        emit(encode(LDW, 4'd4, 4'd3, 16'h005C));
        emit(encode(STW, 4'd4, 4'd0, 16'h9108));
        emit(encode(LDW, 4'd5, 4'd3, 16'hFFE0));
        emit(encode(STW, 4'd5, 4'd3, 16'h90EC));
        emit(encode(HALT, 4'd0, 4'd0, 16'h0000));
        run_program(1'b0);
    endtask

    task automatic mem_roundtrip_test();
        reset_image();
        emit(encode(ADDI, 4'd1, 4'd0, 16'h1234));
        emit(encode(STW, 4'd1, 4'd0, 16'h0008));
        emit(encode(LDW, 4'd2, 4'd0, 16'h0008));
        emit(encode(STW, 4'd2, 4'd0, 16'h9200));
        emit(encode(ADDI, 4'd3, 4'd0, 16'hFFFF));
        emit(encode(STW, 4'd3, 4'd0, 16'h0050));
        emit(encode(LDW, 4'd4, 4'd0, 16'h0050));
        emit(encode(STW, 4'd4, 4'd0, 16'h9204));
        emit(encode(STW, 4'd1, 4'd0, 16'h8FFC));    // just below the host window
        emit(encode(LDW, 4'd6, 4'd0, 16'h007C));
        emit(encode(STW, 4'd6, 4'd0, 16'h9208));
        emit(encode(HALT, 4'd0, 4'd0, 16'h0000));
        run_program(1'b0);
    endtask

    task automatic backpressure_test();
        alu_op_t  rr_ops [5];
        reg_idx_t dst;
        rr_ops = '{ADD, SUB, AND, OR, XOR};
        reset_image();
        for (int r = 1; r <= 6; r++)
            emit(encode(ADDI, reg_idx_t'(r), 4'd0, 16'($random(seed))));
        for (int k = 0; k < 8; k++) begin
            dst = reg_idx_t'(1 + $unsigned($random(seed)) % 7);
            emit(rr_form(rr_ops[$unsigned($random(seed)) % 5], dst,
                         reg_idx_t'(1 + $unsigned($random(seed)) % 7),
                         reg_idx_t'(1 + $unsigned($random(seed)) % 7)));
            emit(encode(STW, dst, 4'd0, 16'h9300 + 16'(4 * k)));
        end
        emit(encode(HALT, 4'd0, 4'd0, 16'h0000));
        emit(encode(STW, 4'd1, 4'd0, 16'h9400));    // behind halt, never issued
        run_program(1'b1);
    endtask

    initial begin
        seed        = 32'h568df985;
        checks      = 0;
        mismatches  = 0;
        faults      = 0;
        rst_n       = 1'b0;
        ready       = 1'b0;
        rd_valid    = 1'b0;
        tx_done     = 1'b0;
        load_data   = '0;
        alu_chain_test();
        load_return_test();
        mem_roundtrip_test();
        backpressure_test();
        $display("Done: %0d checks, %0d mismatches, %0d other errors",
                 checks, mismatches, faults);
        if (mismatches == 0 && faults == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb/cpu_properties.sv
// host link checks bound to cpu_top; write stability assumes tx_done stays low in the first write cycle
`timescale 1ns/10ps
module cpu_properties import cpu_pkg::*; (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   tx_done,
    input host_op_t               host_op,
    input logic [HOST_ADDR_W-1:0] host_addr,
    input word_t                  store_data
);

    ////////////////////////////////////////
    // host link
    ////////////////////////////////////////
    no_unused_op: assert property (@(posedge clk) disable iff (!rst_n)
        host_op != UNUSED)
        else $error("host_op carried the unused code");

    write_in_window: assert property (@(posedge clk) disable iff (!rst_n)
        host_op == WRITE |-> host_addr >= HOST_ADDR_W'(HOST_BASE))
        else $error("host write below the host window");

    // address and data hold until the host ends the transfer
    write_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (host_op == WRITE && !tx_done) |=>
            (host_op == WRITE && $stable(host_addr) && $stable(store_data)))
        else $error("host write changed before tx_done");

    idle_in_reset: assert property (@(posedge clk)
        !rst_n |-> host_op == IDLE)
        else $error("host_op not idle during reset");

endmodule

bind cpu_top cpu_properties cpu_properties_inst (
    .clk(clk),
    .rst_n(rst_n),
    .tx_done(tx_done),
    .host_op(host_op),
    .host_addr(host_addr),
    .store_data(store_data)
);

//--- hw/cpu_top.sv
// chip top; the host must keep the block order and timing that boot_ctrl expects
`timescale 1ns/10ps
module cpu_top import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ready,
    input  logic                   rd_valid,
    input  logic                   tx_done,
    input  word_t                  load_data,
    output host_op_t               host_op,
    output logic [HOST_ADDR_W-1:0] host_addr,
    output word_t                  store_data
);

    logic        freeze;
    logic        im_wr_en, dm_wr_en;
    mem_idx_t    im_wr_idx, dm_wr_idx;
    instr_t      im_wr_data;
    word_t       dm_wr_data;
    mem_idx_t    im_rd_idx, dm_rd_idx;
    instr_t      im_rd_data;
    word_t       dm_rd_data;
    logic        store_en;
    logic [15:0] store_addr;
    word_t       core_store_data;

    boot_ctrl boot_ctrl_inst (
        .clk(clk), .rst_n(rst_n),
        .ready(ready), .rd_valid(rd_valid), .tx_done(tx_done), .load_data(load_data),
        .store_en(store_en), .store_addr(store_addr), .core_store_data(core_store_data),
        .host_op(host_op), .host_addr(host_addr), .store_data(store_data),
        .im_wr_en(im_wr_en), .im_wr_idx(im_wr_idx), .im_wr_data(im_wr_data),
        .dm_wr_en(dm_wr_en), .dm_wr_idx(dm_wr_idx), .dm_wr_data(dm_wr_data),
        .freeze(freeze)
    );

    // program store
    word_mem #(.payload_t(instr_t)) instr_mem (
        .clk(clk), .wr_en(im_wr_en), .wr_idx(im_wr_idx), .wr_data(im_wr_data),
        .rd_idx(im_rd_idx), .rd_data(im_rd_data)
    );

    // data store
    word_mem #(.payload_t(word_t)) data_mem (
        .clk(clk), .wr_en(dm_wr_en), .wr_idx(dm_wr_idx), .wr_data(dm_wr_data),
        .rd_idx(dm_rd_idx), .rd_data(dm_rd_data)
    );

    pipe_core pipe_core_inst (
        .clk(clk), .rst_n(rst_n), .freeze(freeze),
        .im_rd_data(im_rd_data), .dm_rd_data(dm_rd_data),
        .im_rd_idx(im_rd_idx), .dm_rd_idx(dm_rd_idx),
        .store_en(store_en), .store_addr(store_addr), .store_data(core_store_data)
    );

endmodule

//--- hw/boot_ctrl.sv
// boot and host sequencer; each block must arrive as back-to-back words, word 15 with tx_done
`timescale 1ns/10ps
module boot_ctrl import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ready,
    input  logic                   rd_valid,
    input  logic                   tx_done,
    input  word_t                  load_data,
    input  logic                   store_en,
    input  logic [15:0]            store_addr,
    input  word_t                  core_store_data,
    output host_op_t               host_op,
    output logic [HOST_ADDR_W-1:0] host_addr,
    output word_t                  store_data,
    output logic                   im_wr_en,
    output mem_idx_t               im_wr_idx,
    output instr_t                 im_wr_data,
    output logic                   dm_wr_en,
    output mem_idx_t               dm_wr_idx,
    output word_t                  dm_wr_data,
    output logic                   freeze
);

    typedef enum logic [2:0] {
        S_IDLE, S_WAIT_DM, S_LOAD_DM, S_WAIT_IM, S_LOAD_IM, S_RUN, S_HOST_WR
    } state_t;

    state_t               state, next_state;
    logic [BLK_CNT_W-1:0] blk_cnt;
    mem_idx_t             word_addr;   // next load slot
    logic [15:0]          blk_base;
    logic                 in_im, in_wait, in_load, last_blk;
    logic                 load_wr, host_store, local_store;
    mem_idx_t             load_idx;
    logic [15:0]          hw_addr;     // open host write
    word_t                hw_data;

    assign in_im    = (state == S_WAIT_IM) || (state == S_LOAD_IM);
    assign in_wait  = (state == S_WAIT_DM) || (state == S_WAIT_IM);
    assign in_load  = (state == S_LOAD_DM) || (state == S_LOAD_IM);
    assign blk_base = in_im ? IM_BLOCK_BASE[blk_cnt] : DM_BLOCK_BASE[blk_cnt];
    assign last_blk = in_im ? (blk_cnt == BLK_CNT_W'(IM_BLOCKS - 1))
                            : (blk_cnt == BLK_CNT_W'(DM_BLOCKS - 1));

    assign host_store  = store_en && (store_addr >= HOST_BASE);
    assign local_store = (state == S_RUN) && store_en && !host_store;
    assign freeze      = (state != S_RUN);

    ////////////////////////////////////////
    // memory write ports
    ////////////////////////////////////////
    assign load_wr  = (in_wait && rd_valid) || in_load;
    assign load_idx = in_wait ? blk_base[6:2] : word_addr;   // word 0 lands on the base

    assign im_wr_en   = load_wr && in_im;
    assign im_wr_idx  = load_idx;
    assign im_wr_data = instr_t'(load_data);

    assign dm_wr_en   = (load_wr && !in_im) || local_store;
    assign dm_wr_idx  = (state == S_RUN) ? store_addr[6:2] : load_idx;
    assign dm_wr_data = (state == S_RUN) ? core_store_data : load_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            blk_cnt   <= '0;
            word_addr <= '0;
        end else begin
            state <= next_state;
            if (in_wait && rd_valid)
                word_addr <= blk_base[6:2] + 1'b1;
            else if (in_load)
                word_addr <= word_addr + 1'b1;
            if (in_load && tx_done)
                blk_cnt <= last_blk ? '0 : blk_cnt + 1'b1;   // tables restart for the im pass
        end
    end

    // capture the store while it leaves execute
    always_ff @(posedge clk) begin
        if (state == S_RUN && host_store) begin
            hw_addr <= store_addr;
            hw_data <= core_store_data;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE:    if (ready) next_state = S_WAIT_DM;
            S_WAIT_DM: if (rd_valid) next_state = S_LOAD_DM;
            S_LOAD_DM: if (tx_done) next_state = last_blk ? S_WAIT_IM : S_WAIT_DM;
            S_WAIT_IM: if (rd_valid) next_state = S_LOAD_IM;
            S_LOAD_IM: if (tx_done) next_state = last_blk ? S_RUN : S_WAIT_IM;
            S_RUN:     if (host_store) next_state = S_HOST_WR;
            S_HOST_WR: if (tx_done) next_state = S_RUN;
            default:   next_state = S_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // host link
    ////////////////////////////////////////
    always_comb begin
        host_op    = IDLE;
        host_addr  = '0;
        store_data = '0;
        if (in_wait || in_load) begin
            host_op                 = READ;
            host_addr[15:0]         = blk_base;
            host_addr[IM_SPACE_BIT] = in_im;   // marks program space
        end else if (state == S_RUN && host_store) begin
            host_op         = WRITE;
            host_addr[15:0] = store_addr;
            store_data      = core_store_data;
        end else if (state == S_HOST_WR) begin
            host_op         = WRITE;
            host_addr[15:0] = hw_addr;
            store_data      = hw_data;
        end
    end

endmodule

//--- hw/pipe_core.sv
// four-stage in-order core with no forwarding; pc is a word index that wraps at 32 entries
`timescale 1ns/10ps
module pipe_core import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        freeze,
    input  instr_t      im_rd_data,
    input  word_t       dm_rd_data,
    output mem_idx_t    im_rd_idx,
    output mem_idx_t    dm_rd_idx,
    output logic        store_en,
    output logic [15:0] store_addr,
    output word_t       store_data
);

    mem_idx_t pc, pc_next;
    // decode
    instr_t   dc_instr;
    alu_op_t  dc_op;
    logic     dc_imm_sel, dc_wr_en, dc_load, dc_store, dc_halt;
    logic     dc_a_used, dc_b_used, stall;
    reg_idx_t dc_src_b;
    word_t    dc_a, dc_b, dc_imm;
    // execute
    alu_op_t  ex_op;
    logic     ex_imm_sel, ex_wr_en, ex_load, ex_store;
    reg_idx_t ex_dst;
    word_t    ex_a, ex_b, ex_imm, ex_opnd_b, ex_result;
    // writeback
    logic     wb_wr_en, wb_load;
    reg_idx_t wb_dst;
    word_t    wb_result, wb_data;

    ////////////////////////////////////////
    // fetch
    ////////////////////////////////////////
    // memory output register doubles as the decode stage, so it is read at pc_next
    assign pc_next   = (freeze || stall || dc_halt) ? pc : pc + 1'b1;
    assign im_rd_idx = pc_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= '0;
        else
            pc <= pc_next;
    end

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    assign dc_instr = im_rd_data;
    assign dc_halt  = (dc_instr.opcode == HALT);
    assign dc_src_b = dc_store ? dc_instr.rd : dc_instr.imm[15:12];   // rd is store data
    assign dc_imm   = {{16{dc_instr.imm[15]}}, dc_instr.imm};

    always_comb begin
        dc_op      = NOP;
        dc_imm_sel = 1'b0;
        dc_wr_en   = 1'b0;
        dc_load    = 1'b0;
        dc_store   = 1'b0;
        dc_a_used  = 1'b0;
        dc_b_used  = 1'b0;
        case (alu_op_t'(dc_instr.opcode))
            ADD, SUB, AND, OR, XOR: begin
                dc_op     = alu_op_t'(dc_instr.opcode);
                dc_wr_en  = 1'b1;
                dc_a_used = 1'b1;
                dc_b_used = 1'b1;
            end
            ADDI, LDW: begin
                dc_op      = alu_op_t'(dc_instr.opcode);
                dc_imm_sel = 1'b1;
                dc_wr_en   = 1'b1;
                dc_load    = (dc_instr.opcode == LDW);
                dc_a_used  = 1'b1;
            end
            STW: begin
                dc_op      = STW;
                dc_imm_sel = 1'b1;
                dc_store   = 1'b1;
                dc_a_used  = 1'b1;
                dc_b_used  = 1'b1;
            end
            default: ;   // nop, halt and unknown codes
        endcase
    end

    reg_file reg_file_inst (
        .clk(clk), .rst_n(rst_n),
        .rd_sel_a(dc_instr.rs), .rd_sel_b(dc_src_b),
        .wr_sel(wb_dst), .wr_en(wb_wr_en && !freeze), .wr_data(wb_data),
        .rd_a(dc_a), .rd_b(dc_b)
    );

    hazard_unit hazard_unit_inst (
        .src_a(dc_instr.rs), .src_b(dc_src_b),
        .src_a_used(dc_a_used), .src_b_used(dc_b_used),
        .ex_dst(ex_dst), .ex_wr_en(ex_wr_en),
        .wb_dst(wb_dst), .wb_wr_en(wb_wr_en),
        .stall(stall)
    );

    ////////////////////////////////////////
    // execute and writeback
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_op    <= NOP;
            ex_wr_en <= 1'b0;
            ex_load  <= 1'b0;
            ex_store <= 1'b0;
            wb_wr_en <= 1'b0;
            wb_load  <= 1'b0;
        end else if (!freeze) begin
            ex_op    <= stall ? NOP : dc_op;   // bubble while decode waits
            ex_wr_en <= dc_wr_en && !stall;
            ex_load  <= dc_load && !stall;
            ex_store <= dc_store && !stall;
            wb_wr_en <= ex_wr_en;
            wb_load  <= ex_load;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            ex_imm_sel <= dc_imm_sel;
            ex_dst     <= dc_instr.rd;
            ex_a       <= dc_a;
            ex_b       <= dc_b;
            ex_imm     <= dc_imm;
            wb_dst     <= ex_dst;
            wb_result  <= ex_result;
        end
    end

    assign ex_opnd_b = ex_imm_sel ? ex_imm : ex_b;

    cpu_alu cpu_alu_inst (.a(ex_a), .b(ex_opnd_b), .op(ex_op), .result(ex_result));

    assign dm_rd_idx  = ex_result[6:2];   // load data shows up in writeback
    assign store_en   = ex_store;
    assign store_addr = ex_result[15:0];
    assign store_data = ex_b;
    assign wb_data    = wb_load ? dm_rd_data : wb_result;

endmodule

//--- hw/word_mem.sv
// single-port write, single-port read memory; a read in the write cycle returns the old entry
`timescale 1ns/10ps
module word_mem import cpu_pkg::*; #(
    parameter type payload_t = word_t
) (
    input  logic     clk,
    input  logic     wr_en,
    input  mem_idx_t wr_idx,
    input  payload_t wr_data,
    input  mem_idx_t rd_idx,
    output payload_t rd_data
);

    payload_t mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_idx] <= wr_data;
    end

    // registered read, one cycle after rd_idx
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];
    end

endmodule

//--- hw/hazard_unit.sv
// read-after-write detect; relies on register file write-through for the writeback stage
`timescale 1ns/10ps
module hazard_unit import cpu_pkg::*; #(
    parameter bit WB_WRITE_THROUGH = 1'b1   // clear for a register file without bypass
) (
    input  reg_idx_t src_a,
    input  reg_idx_t src_b,
    input  logic     src_a_used,
    input  logic     src_b_used,
    input  reg_idx_t ex_dst,
    input  logic     ex_wr_en,
    input  reg_idx_t wb_dst,
    input  logic     wb_wr_en,
    output logic     stall
);

    logic ex_hit, wb_hit;

    assign ex_hit = ex_wr_en && ((src_a_used && src_a == ex_dst) ||
                                 (src_b_used && src_b == ex_dst));
    assign wb_hit = wb_wr_en && ((src_a_used && src_a == wb_dst) ||
                                 (src_b_used && src_b == wb_dst));

    // writeback match resolves in the same cycle
    assign stall = ex_hit || (wb_hit && !WB_WRITE_THROUGH);

endmodule

//--- hw/reg_file.sv
// 16 x 32 register file; r0 is an ordinary register and is writable
`timescale 1ns/10ps
module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rd_sel_a,
    input  reg_idx_t rd_sel_b,
    input  reg_idx_t wr_sel,
    input  logic     wr_en,
    input  word_t    wr_data,
    output word_t    rd_a,
    output word_t    rd_b
);

    word_t regs [2**$bits(reg_idx_t)];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**$bits(reg_idx_t); i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // write-through, decode sees the writeback value
    assign rd_a = (wr_en && wr_sel == rd_sel_a) ? wr_data : regs[rd_sel_a];
    assign rd_b = (wr_en && wr_sel == rd_sel_b) ? wr_data : regs[rd_sel_b];

endmodule

//--- hw/cpu_alu.sv
// combinational ALU without flags; codes it does not know give zero
`timescale 1ns/10ps
module cpu_alu import cpu_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    always_comb begin
        case (op)
            ADD, ADDI, LDW, STW: result = a + b;   // address math shares the adder
            SUB:                 result = a - b;
            AND:                 result = a & b;
            OR:                  result = a | b;
            XOR:                 result = a ^ b;
            default:             result = '0;
        endcase
    end

endmodule

//--- hw/cpu_pkg.sv
// shared types and constants; each memory holds 32 words, so every block must sit below byte 0x80
package cpu_pkg;

    ////////////////////////////////////////
    // basic types
    ////////////////////////////////////////
    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [4:0]  mem_idx_t;   // byte address bits 6:2

    typedef struct packed {
        logic [7:0]  opcode;
        reg_idx_t    rd;     // destination, store data source
        reg_idx_t    rs;
        logic [15:0] imm;    // rt in the top nibble
    } instr_t;

    // host link opcodes
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        READ   = 2'd1,
        UNUSED = 2'd2,
        WRITE  = 2'd3
    } host_op_t;

    // unknown values run as nop
    typedef enum logic [7:0] {
        NOP  = 8'h00,
        ADD  = 8'h10,
        SUB  = 8'h11,
        AND  = 8'h12,
        OR   = 8'h13,
        XOR  = 8'h14,
        ADDI = 8'h18,
        LDW  = 8'h80,  // rs + imm
        STW  = 8'h83,  // mem[rs + imm] = rd
        HALT = 8'hFF
    } alu_op_t;

    ////////////////////////////////////////
    // boot tables and address map
    ////////////////////////////////////////
    localparam int BLOCK_WORDS = 16;
    localparam int DM_BLOCKS   = 2;
    localparam int IM_BLOCKS   = 2;
    localparam logic [15:0] DM_BLOCK_BASE [DM_BLOCKS] = '{16'h0000, 16'h0040};
    localparam logic [15:0] IM_BLOCK_BASE [IM_BLOCKS] = '{16'h0000, 16'h0040};
    localparam int BLK_CNT_W = (DM_BLOCKS > IM_BLOCKS) ? $clog2(DM_BLOCKS) : $clog2(IM_BLOCKS);

    localparam int          MEM_WORDS    = 32;
    localparam logic [15:0] HOST_BASE    = 16'h9000;  // stores from here up go to the host
    localparam int          IM_SPACE_BIT = 16;
    localparam int          HOST_ADDR_W  = 64;

endpackage
